/* files.f */
hw/acc_split_param_pkg.sv
hw/ntt_stream_pkg.sv
hw/gram_lane_writer.sv
hw/acc_subs_side.sv
hw/slr_crossing.sv
hw/acc_split_assembly.sv
verification/tb_acc_split.sv

/* hw/acc_split_assembly.sv */
// Split accumulator assembly
`timescale 1ns/1ps

module acc_split_assembly #(
  parameter int SLR_LATENCY = 6
) (
  input  logic                                                       clk,
  input  logic                                                       s_rst_n,
  input  ntt_stream_pkg::ntt_full_beat_t                             ntt_in,
  input  acc_split_param_pkg::gram_1h_t                              wr_avail_1h,
  output logic [acc_split_param_pkg::GRAM_NB-1:0][acc_split_param_pkg::PSI-1:0]
               [acc_split_param_pkg::R-1:0]                          gram_wr_en,
  output acc_split_param_pkg::gram_add_t [acc_split_param_pkg::GRAM_NB-1:0]
         [acc_split_param_pkg::PSI-1:0][acc_split_param_pkg::R-1:0] gram_wr_add,
  output acc_split_param_pkg::coef_t [acc_split_param_pkg::GRAM_NB-1:0]
         [acc_split_param_pkg::PSI-1:0][acc_split_param_pkg::R-1:0] gram_wr_data,
  output acc_split_param_pkg::acc_error_t                            error
);

  // SLR_LATENCY must be at least 2 so that each direction keeps one stage
  localparam int OUTWARD_SLR_LATENCY = SLR_LATENCY / 2;
  localparam int RETURN_SLR_LATENCY  = SLR_LATENCY - OUTWARD_SLR_LATENCY;

  localparam int GRAM_NB   = acc_split_param_pkg::GRAM_NB;
  localparam int R         = acc_split_param_pkg::R;
  localparam int QPSI      = acc_split_param_pkg::QPSI;
  localparam int SUBS_PSI  = acc_split_param_pkg::SUBS_PSI;
  localparam int MAIN_PSI  = acc_split_param_pkg::MAIN_PSI;
  localparam int SUBS_DIV  = acc_split_param_pkg::MSPLIT_SUBS_FACTOR;
  localparam int SPLIT_DIV = acc_split_param_pkg::MSPLIT_DIV;

  ntt_stream_pkg::ntt_main_beat_t main_beat_in;
  ntt_stream_pkg::ntt_main_beat_t main_beat_out;
  ntt_stream_pkg::slr_return_t    ret_in;
  ntt_stream_pkg::slr_return_t    ret_out;
  logic                           subs_overflow;
  logic                           main_overflow;

  // Writer ports in quarter order
  logic [GRAM_NB-1:0][SUBS_PSI-1:0][R-1:0]                              subs_wr_en;
  acc_split_param_pkg::gram_add_t [GRAM_NB-1:0][SUBS_PSI-1:0][R-1:0]    subs_wr_add;
  acc_split_param_pkg::coef_t [GRAM_NB-1:0][SUBS_PSI-1:0][R-1:0]        subs_wr_data;
  logic [GRAM_NB-1:0][MAIN_PSI-1:0][R-1:0]                              main_wr_en;
  acc_split_param_pkg::gram_add_t [GRAM_NB-1:0][MAIN_PSI-1:0][R-1:0]    main_wr_add;
  acc_split_param_pkg::coef_t [GRAM_NB-1:0][MAIN_PSI-1:0][R-1:0]        main_wr_data;

  // --------------------------------------------------------------------------
  // Subs half and crossing
  // --------------------------------------------------------------------------
  acc_subs_side #(
    .NB_GROUPS (SUBS_PSI)
  ) u_subs_side (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .ntt_in       (ntt_in),
    .wr_avail_1h  (ret_out.wr_avail_1h),
    .main_beat    (main_beat_in),
    .gram_wr_en   (subs_wr_en),
    .gram_wr_add  (subs_wr_add),
    .gram_wr_data (subs_wr_data),
    .subs_error   (subs_overflow)
  );

  assign ret_in.wr_avail_1h = wr_avail_1h;
  assign ret_in.subs_error  = subs_overflow;

  slr_crossing #(
    .OUTWARD_LATENCY (OUTWARD_SLR_LATENCY),
    .RETURN_LATENCY  (RETURN_SLR_LATENCY)
  ) u_slr_crossing (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .main_in  (main_beat_in),
    .main_out (main_beat_out),
    .ret_in   (ret_in),
    .ret_out  (ret_out)
  );

  // --------------------------------------------------------------------------
  // Main half
  // --------------------------------------------------------------------------
  // Main side sits next to the GRAM arbiter and sees the one-hot directly
  gram_lane_writer #(
    .NB_GROUPS (MAIN_PSI)
  ) u_main_writer (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .beat         (main_beat_out),
    .wr_avail_1h  (wr_avail_1h),
    .gram_wr_en   (main_wr_en),
    .gram_wr_add  (main_wr_add),
    .gram_wr_data (main_wr_data),
    .overflow     (main_overflow)
  );

  assign error = {main_overflow, ret_out.subs_error};

  // --------------------------------------------------------------------------
  // GRAM lane interleave
  // --------------------------------------------------------------------------
  // Quarter i group p lands on lane i*QPSI+p
  always_comb begin
    for (int i = 0; i < SUBS_DIV; i++) begin
      for (int b = 0; b < GRAM_NB; b++) begin
        for (int p = 0; p < QPSI; p++) begin
          gram_wr_en[b][i*QPSI+p]   = subs_wr_en[b][i*QPSI+p];
          gram_wr_add[b][i*QPSI+p]  = subs_wr_add[b][i*QPSI+p];
          gram_wr_data[b][i*QPSI+p] = subs_wr_data[b][i*QPSI+p];
        end
      end
    end
    for (int i = SUBS_DIV; i < SPLIT_DIV; i++) begin
      for (int b = 0; b < GRAM_NB; b++) begin
        for (int p = 0; p < QPSI; p++) begin
          gram_wr_en[b][i*QPSI+p]   = main_wr_en[b][(i-SUBS_DIV)*QPSI+p];
          gram_wr_add[b][i*QPSI+p]  = main_wr_add[b][(i-SUBS_DIV)*QPSI+p];
          gram_wr_data[b][i*QPSI+p] = main_wr_data[b][(i-SUBS_DIV)*QPSI+p];
        end
      end
    end
  end

endmodule

/* hw/acc_split_param_pkg.sv */
// Accumulator split geometry
package acc_split_param_pkg;

  // --------------------------------------------------------------------------
  // NTT output stream shape
  // --------------------------------------------------------------------------
  localparam int PSI = 4;
  localparam int R   = 2;

  // Quarter slices shared between the subs and main halves
  localparam int MSPLIT_DIV         = 4;
  localparam int MSPLIT_SUBS_FACTOR = 1;
  localparam int MSPLIT_MAIN_FACTOR = 3;
  localparam int QPSI               = PSI / MSPLIT_DIV;
  localparam int SUBS_PSI           = MSPLIT_SUBS_FACTOR * QPSI;
  localparam int MAIN_PSI           = MSPLIT_MAIN_FACTOR * QPSI;

  // --------------------------------------------------------------------------
  // GRAM and stream field widths
  // --------------------------------------------------------------------------
  localparam int GRAM_NB    = 2;
  localparam int MOD_Q_W    = 16;
  localparam int GRAM_ADD_W = 6;
  localparam int BPBS_ID_W  = 4;

  // Bit 0 subs overflow and bit 1 main overflow
  localparam int ACC_ERROR_W = 2;

  typedef logic [MOD_Q_W-1:0]     coef_t;
  typedef logic [GRAM_ADD_W-1:0]  gram_add_t;
  typedef logic [BPBS_ID_W-1:0]   pbs_id_t;
  typedef logic [GRAM_NB-1:0]     gram_1h_t;
  typedef logic [ACC_ERROR_W-1:0] acc_error_t;

endpackage

/* hw/acc_subs_side.sv */
// Accumulator subs half
`timescale 1ns/1ps

module acc_subs_side #(
  parameter int NB_GROUPS = 1
) (
  input  logic                                                      clk,
  input  logic                                                      s_rst_n,
  input  ntt_stream_pkg::ntt_full_beat_t                            ntt_in,
  input  acc_split_param_pkg::gram_1h_t                             wr_avail_1h,
  output ntt_stream_pkg::ntt_main_beat_t                            main_beat,
  output logic [acc_split_param_pkg::GRAM_NB-1:0][NB_GROUPS-1:0][acc_split_param_pkg::R-1:0]
                                                                    gram_wr_en,
  output acc_split_param_pkg::gram_add_t [acc_split_param_pkg::GRAM_NB-1:0][NB_GROUPS-1:0]
                                         [acc_split_param_pkg::R-1:0] gram_wr_add,
  output acc_split_param_pkg::coef_t [acc_split_param_pkg::GRAM_NB-1:0][NB_GROUPS-1:0]
                                     [acc_split_param_pkg::R-1:0]     gram_wr_data,
  output logic                                                      subs_error
);

  localparam int MAIN_PSI = acc_split_param_pkg::MAIN_PSI;
  localparam int R        = acc_split_param_pkg::R;

  logic [NB_GROUPS*ntt_stream_pkg::GROUP_W+ntt_stream_pkg::CTRL_W-1:0] subs_beat;
  ntt_stream_pkg::ntt_main_beat_t main_d;
  ntt_stream_pkg::ntt_main_beat_t main_q;
  logic [MAIN_PSI-1:0][R-1:0]     main_avail_q;
  logic                           main_ctrl_avail_q;

  // --------------------------------------------------------------------------
  // Lane split
  // --------------------------------------------------------------------------
  // Lowest slices stay here
  assign subs_beat = {ntt_in.grp[NB_GROUPS-1:0], ntt_in.ctrl};

  always_comb begin
    main_d.grp  = ntt_in.grp[NB_GROUPS +: MAIN_PSI];
    main_d.ctrl = ntt_in.ctrl;
  end

  // --------------------------------------------------------------------------
  // Main beat register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      main_avail_q      <= '0;
      main_ctrl_avail_q <= 1'b0;
    end else begin
      main_ctrl_avail_q <= main_d.ctrl.ctrl_avail;
      for (int p = 0; p < MAIN_PSI; p++) begin
        main_avail_q[p] <= main_d.grp[p].avail;
      end
    end
  end

  always_ff @(posedge clk) begin
    main_q <= main_d;
  end

  // Valid bits come from the reset flops
  always_comb begin
    main_beat                 = main_q;
    main_beat.ctrl.ctrl_avail = main_ctrl_avail_q;
    for (int p = 0; p < MAIN_PSI; p++) begin
      main_beat.grp[p].avail = main_avail_q[p];
    end
  end

  // --------------------------------------------------------------------------
  // Subs writer
  // --------------------------------------------------------------------------
  gram_lane_writer #(
    .NB_GROUPS (NB_GROUPS)
  ) u_subs_writer (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .beat         (subs_beat),
    .wr_avail_1h  (wr_avail_1h),
    .gram_wr_en   (gram_wr_en),
    .gram_wr_add  (gram_wr_add),
    .gram_wr_data (gram_wr_data),
    .overflow     (subs_error)
  );

endmodule

/* hw/gram_lane_writer.sv */
// GRAM lane writer
`timescale 1ns/1ps

module gram_lane_writer #(
  parameter int NB_GROUPS = 1
) (
  input  logic                                                       clk,
  input  logic                                                       s_rst_n,
  input  logic [NB_GROUPS*ntt_stream_pkg::GROUP_W+ntt_stream_pkg::CTRL_W-1:0] beat,
  input  acc_split_param_pkg::gram_1h_t                              wr_avail_1h,
  output logic [acc_split_param_pkg::GRAM_NB-1:0][NB_GROUPS-1:0][acc_split_param_pkg::R-1:0]
                                                                     gram_wr_en,
  output acc_split_param_pkg::gram_add_t [acc_split_param_pkg::GRAM_NB-1:0][NB_GROUPS-1:0]
                                         [acc_split_param_pkg::R-1:0] gram_wr_add,
  output acc_split_param_pkg::coef_t [acc_split_param_pkg::GRAM_NB-1:0][NB_GROUPS-1:0]
                                     [acc_split_param_pkg::R-1:0]     gram_wr_data,
  output logic                                                       overflow
);

  localparam int GRAM_NB = acc_split_param_pkg::GRAM_NB;
  localparam int R       = acc_split_param_pkg::R;

  ntt_stream_pkg::ntt_group_t [NB_GROUPS-1:0]        grp;
  ntt_stream_pkg::ntt_ctrl_t                         ctrl;
  logic                                              bank_ok;
  logic                                              wr_go;
  acc_split_param_pkg::gram_add_t                    beat_cnt;
  acc_split_param_pkg::gram_add_t                    cur_add;
  acc_split_param_pkg::gram_add_t                    add_q;
  acc_split_param_pkg::coef_t [NB_GROUPS-1:0][R-1:0] data_q;

  assign {grp, ctrl} = beat;

  // Exactly one bank may take the beat
  assign bank_ok = $onehot(wr_avail_1h);
  assign wr_go   = ctrl.ctrl_avail & bank_ok;

  // --------------------------------------------------------------------------
  // Batch address
  // --------------------------------------------------------------------------
  // Address is the beat index within the batch
  assign cur_add = ctrl.sob ? '0 : beat_cnt;

  // Dropped beats still count
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      beat_cnt <= '0;
    end else if (ctrl.ctrl_avail) begin
      beat_cnt <= cur_add + acc_split_param_pkg::gram_add_t'(1);
    end
  end

  // --------------------------------------------------------------------------
  // Write ports
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      gram_wr_en <= '0;
    end else begin
      for (int b = 0; b < GRAM_NB; b++) begin
        for (int g = 0; g < NB_GROUPS; g++) begin
          gram_wr_en[b][g] <= (wr_go && wr_avail_1h[b]) ? grp[g].avail : '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.ctrl_avail) begin
      add_q <= cur_add;
      for (int g = 0; g < NB_GROUPS; g++) begin
        data_q[g] <= grp[g].data;
      end
    end
  end

  // Same address and data offered to both banks
  always_comb begin
    for (int b = 0; b < GRAM_NB; b++) begin
      for (int g = 0; g < NB_GROUPS; g++) begin
        for (int r = 0; r < R; r++) begin
          gram_wr_add[b][g][r]  = add_q;
          gram_wr_data[b][g][r] = data_q[g][r];
        end
      end
    end
  end

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      overflow <= 1'b0;
    end else if (ctrl.ctrl_avail && !bank_ok) begin
      overflow <= 1'b1;
    end
  end

endmodule

/* hw/ntt_stream_pkg.sv */
// NTT stream and return types
package ntt_stream_pkg;

  // One lane group with its per-coefficient avail
  typedef struct packed {
    logic [acc_split_param_pkg::R-1:0]                avail;
    acc_split_param_pkg::coef_t [acc_split_param_pkg::R-1:0] data;
  } ntt_group_t;

  // Beat markers
  typedef struct packed {
    logic                         ctrl_avail;
    logic                         sob;
    logic                         eob;
    logic                         sol;
    logic                         eol;
    logic                         sog;
    logic                         eog;
    acc_split_param_pkg::pbs_id_t pbs_id;
  } ntt_ctrl_t;

  localparam int GROUP_W = $bits(ntt_group_t);
  localparam int CTRL_W  = $bits(ntt_ctrl_t);

  // Groups sit above the markers so that a narrower beat keeps the same layout
  typedef struct packed {
    ntt_group_t [acc_split_param_pkg::PSI-1:0] grp;
    ntt_ctrl_t                                  ctrl;
  } ntt_full_beat_t;

  typedef struct packed {
    ntt_group_t [acc_split_param_pkg::MAIN_PSI-1:0] grp;
    ntt_ctrl_t                                       ctrl;
  } ntt_main_beat_t;

  typedef struct packed {
    acc_split_param_pkg::gram_1h_t wr_avail_1h;
    logic                          subs_error;
  } slr_return_t;

endpackage

/* hw/slr_crossing.sv */
// SLR boundary pipelines
`timescale 1ns/1ps

module slr_crossing #(
  parameter int OUTWARD_LATENCY = 3,
  parameter int RETURN_LATENCY  = 3
) (
  input  logic                           clk,
  input  logic                           s_rst_n,
  input  ntt_stream_pkg::ntt_main_beat_t main_in,
  output ntt_stream_pkg::ntt_main_beat_t main_out,
  input  ntt_stream_pkg::slr_return_t    ret_in,
  output ntt_stream_pkg::slr_return_t    ret_out
);

  localparam int MAIN_PSI = acc_split_param_pkg::MAIN_PSI;
  localparam int R        = acc_split_param_pkg::R;

  ntt_stream_pkg::ntt_main_beat_t [OUTWARD_LATENCY-1:0] beat_sr;
  logic [OUTWARD_LATENCY-1:0][MAIN_PSI-1:0][R-1:0]      avail_sr;
  logic [OUTWARD_LATENCY-1:0]                           ctrl_avail_sr;
  logic [MAIN_PSI-1:0][R-1:0]                           avail_in;
  ntt_stream_pkg::slr_return_t [RETURN_LATENCY-1:0]     ret_sr;

  // --------------------------------------------------------------------------
  // Outward path
  // --------------------------------------------------------------------------
  always_comb begin
    for (int p = 0; p < MAIN_PSI; p++) begin
      avail_in[p] = main_in.grp[p].avail;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      avail_sr      <= '0;
      ctrl_avail_sr <= '0;
    end else begin
      avail_sr[0]      <= avail_in;
      ctrl_avail_sr[0] <= main_in.ctrl.ctrl_avail;
      for (int i = 1; i < OUTWARD_LATENCY; i++) begin
        avail_sr[i]      <= avail_sr[i-1];
        ctrl_avail_sr[i] <= ctrl_avail_sr[i-1];
      end
    end
  end

  // Data and markers
  always_ff @(posedge clk) begin
    beat_sr[0] <= main_in;
    for (int i = 1; i < OUTWARD_LATENCY; i++) begin
      beat_sr[i] <= beat_sr[i-1];
    end
  end

  always_comb begin
    main_out                 = beat_sr[OUTWARD_LATENCY-1];
    main_out.ctrl.ctrl_avail = ctrl_avail_sr[OUTWARD_LATENCY-1];
    for (int p = 0; p < MAIN_PSI; p++) begin
      main_out.grp[p].avail = avail_sr[OUTWARD_LATENCY-1][p];
    end
  end

  // --------------------------------------------------------------------------
  // Return path
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      ret_sr <= '0;
    end else begin
      ret_sr[0] <= ret_in;
      for (int i = 1; i < RETURN_LATENCY; i++) begin
        ret_sr[i] <= ret_sr[i-1];
      end
    end
  end

  assign ret_out = ret_sr[RETURN_LATENCY-1];

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the split accumulator testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator was not found on the PATH"
  exit 1
fi

verilator --binary --timing -f files.f --top-module tb_acc_split -o tb_acc_split_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/tb_acc_split_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

/* verification/tb_acc_split.sv */
// Split accumulator testbench
`timescale 1ns/1ps

module tb_acc_split;

  localparam int PSI          = acc_split_param_pkg::PSI;
  localparam int R            = acc_split_param_pkg::R;
  localparam int GRAM_NB      = acc_split_param_pkg::GRAM_NB;
  localparam int SLR_LATENCY  = 6;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int BATCH_LEN    = 16;
  localparam int NB_BATCHES   = 6;
  // Longer than SLR_LATENCY and the main write delay
  localparam int GAP_CYCLES   = 12;
  localparam int TOTAL_BEATS  = RESET_CYCLES + NB_BATCHES * BATCH_LEN
                                + (NB_BATCHES + 4) * GAP_CYCLES;
  localparam int WATCHDOG_NS  = (TOTAL_BEATS + 100) * CLK_PERIOD;

  // One expected GRAM write
  typedef struct packed {
    logic                           valid;
    logic [7:0]                     bank;
    acc_split_param_pkg::gram_add_t add;
    acc_split_param_pkg::coef_t     data;
  } wr_rec_t;

  logic                                   clk = 1'b0;
  logic                                   s_rst_n;
  ntt_stream_pkg::ntt_full_beat_t         ntt_in;
  acc_split_param_pkg::gram_1h_t          wr_avail_1h;
  logic [GRAM_NB-1:0][PSI-1:0][R-1:0]     gram_wr_en;
  acc_split_param_pkg::gram_add_t [GRAM_NB-1:0][PSI-1:0][R-1:0] gram_wr_add;
  acc_split_param_pkg::coef_t [GRAM_NB-1:0][PSI-1:0][R-1:0]     gram_wr_data;
  acc_split_param_pkg::acc_error_t        error;

  wr_rec_t                       exp_q [PSI*R][$];
  acc_split_param_pkg::gram_1h_t avail_held;
  logic [31:0]                   rng_state;
  string                         test_name;
  int                            errors;
  wr_rec_t                       cmp_rec;
  int                            cmp_lane;

  acc_split_assembly #(
    .SLR_LATENCY (SLR_LATENCY)
  ) dut (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .ntt_in       (ntt_in),
    .wr_avail_1h  (wr_avail_1h),
    .gram_wr_en   (gram_wr_en),
    .gram_wr_add  (gram_wr_add),
    .gram_wr_data (gram_wr_data),
    .error        (error)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------------------------------------------------------------
  // Reference model and helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Bank from the one-hot, address from the beat index in the batch
  function automatic wr_rec_t expected_write(input acc_split_param_pkg::gram_1h_t avail_1h,
                                             input int beat_idx,
                                             input acc_split_param_pkg::coef_t data);
    int      nb_set;
    wr_rec_t rec;
    nb_set = 0;
    rec    = '0;
    for (int b = 0; b < GRAM_NB; b++) begin
      if (avail_1h[b]) begin
        nb_set++;
        rec.bank = 8'(b);
      end
    end
    rec.valid = (nb_set == 1);
    rec.add   = acc_split_param_pkg::gram_add_t'(beat_idx);
    rec.data  = data;
    return rec;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      ntt_in <= '0;
    end
  endtask

  task automatic hold_avail(input acc_split_param_pkg::gram_1h_t avail_1h);
    @(posedge clk);
    wr_avail_1h <= avail_1h;
    avail_held = avail_1h;
    idle_cycles(GAP_CYCLES);
  endtask

  task automatic send_batch(input int pbs, input logic random_mask);
    ntt_stream_pkg::ntt_full_beat_t beat;
    wr_rec_t                        rec;
    for (int i = 0; i < BATCH_LEN; i++) begin
      beat                 = '0;
      beat.ctrl.ctrl_avail = 1'b1;
      beat.ctrl.sob        = (i == 0);
      beat.ctrl.eob        = (i == BATCH_LEN - 1);
      beat.ctrl.sol        = (i == 0);
      beat.ctrl.eol        = (i == BATCH_LEN - 1);
      beat.ctrl.sog        = (i == 0);
      beat.ctrl.eog        = (i == BATCH_LEN - 1);
      beat.ctrl.pbs_id     = acc_split_param_pkg::pbs_id_t'(pbs);
      for (int p = 0; p < PSI; p++) begin
        for (int r = 0; r < R; r++) begin
          rng_state = xorshift32(rng_state);
          beat.grp[p].data[r]  = acc_split_param_pkg::coef_t'(rng_state);
          beat.grp[p].avail[r] = random_mask ? rng_state[31] : 1'b1;
          if (beat.grp[p].avail[r]) begin
            rec = expected_write(avail_held, i, beat.grp[p].data[r]);
            if (rec.valid) begin
              exp_q[p*R+r].push_back(rec);
            end
          end
        end
      end
      @(posedge clk);
      ntt_in <= beat;
    end
  endtask

  // --------------------------------------------------------------------------
  // Write comparator, in order per GRAM lane
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    if (s_rst_n === 1'b1) begin
      for (int b = 0; b < GRAM_NB; b++) begin
        for (int p = 0; p < PSI; p++) begin
          for (int r = 0; r < R; r++) begin
            if (gram_wr_en[b][p][r] === 1'b1) begin
              cmp_lane = p * R + r;
              if (exp_q[cmp_lane].size() == 0) begin
                errors++;
                $display("Unexpected write on bank %0d lane %0d during %s", b, cmp_lane,
                         test_name);
              end else begin
                cmp_rec = exp_q[cmp_lane].pop_front();
                check_value({test_name, "_bank"}, 64'(cmp_rec.bank), 64'(b));
                check_value({test_name, "_add"}, 64'(cmp_rec.add), 64'(gram_wr_add[b][p][r]));
                check_value({test_name, "_data"}, 64'(cmp_rec.data),
                            64'(gram_wr_data[b][p][r]));
              end
            end
          end
        end
      end
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Errors: %0d", errors);
    $display("Test FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    s_rst_n     = 1'b0;
    ntt_in      = '0;
    wr_avail_1h = '0;
    avail_held  = '0;
    rng_state   = 32'd52971;
    errors      = 0;
    test_name   = "reset";
    repeat (RESET_CYCLES) @(posedge clk);
    s_rst_n <= 1'b1;
    @(negedge clk);
    check_value("reset_wr_en", 64'd0, 64'(gram_wr_en));
    check_value("reset_error", 64'd0, 64'(error));

    test_name = "full_batch";
    hold_avail(2'b01);
    send_batch(1, 1'b0);
    idle_cycles(GAP_CYCLES);

    // Back to back batches with sob restarting the address
    test_name = "random_mask";
    send_batch(2, 1'b1);
    send_batch(3, 1'b1);
    idle_cycles(GAP_CYCLES);

    test_name = "bank1";
    hold_avail(2'b10);
    send_batch(4, 1'b0);
    idle_cycles(GAP_CYCLES);
    @(negedge clk);
    check_value("no_error", 64'd0, 64'(error));

    test_name = "zero_avail";
    hold_avail(2'b00);
    send_batch(5, 1'b0);
    idle_cycles(GAP_CYCLES);
    @(negedge clk);
    check_value("zero_avail_error", 64'd3, 64'(error));

    // Good beats afterwards leave both error bits set
    test_name = "sticky_error";
    hold_avail(2'b01);
    send_batch(6, 1'b0);
    idle_cycles(GAP_CYCLES);
    @(negedge clk);
    check_value("sticky_error", 64'd3, 64'(error));

    for (int l = 0; l < PSI * R; l++) begin
      if (exp_q[l].size() != 0) begin
        errors++;
        $display("GRAM lane %0d is missing %0d expected writes", l, exp_q[l].size());
      end
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
